// File: verilog/scope_pkg.sv
package scope_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // number of analog channels
  localparam int unsigned CHN   = 2;
  // ADC sample width, 14-bit converter in a 16-bit word
  localparam int unsigned ADC_W = 16;
  // generator and DAC width
  localparam int unsigned GEN_W = 14;

  ////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////

  // acquired sample, two's complement
  typedef logic signed [ADC_W-1:0] osc_t;
  // generator sample, two's complement
  typedef logic signed [GEN_W-1:0] gen_t;
  // DAC code, offset binary with negative slope
  typedef logic        [GEN_W-1:0] dac_t;

  // one capture word, both channels side by side
  typedef struct packed {
    osc_t ch1;
    osc_t ch0;
  } pair_t;

  // gen to osc alignment shift
  localparam int unsigned LOOP_SHIFT = ADC_W - GEN_W;
  // DAC code for mid-scale output
  localparam dac_t DAC_MID = dac_t'((1 << (GEN_W - 1)) - 1);

endpackage

// File: verilog/adc_frontend.sv
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // raw converter words, negative slope
  input  logic [scope_pkg::CHN-1:0][scope_pkg::ADC_W-1:0]  adc_dat_i,
  // generator samples for loopback
  input  scope_pkg::gen_t [scope_pkg::CHN-1:0]             gen_dat_i,
  input  logic [scope_pkg::CHN-1:0]                        loop_i,
  input  logic                                             capture_en_i,
  // towards the capture buffer
  output logic                                             push_o,
  output scope_pkg::pair_t                                 pair_o
);

  ////////////////////////////////////////////////////////////
  // input stage
  ////////////////////////////////////////////////////////////

  logic [scope_pkg::CHN-1:0][scope_pkg::ADC_W-1:0] adc_raw;
  scope_pkg::gen_t [scope_pkg::CHN-1:0]            gen_raw;
  logic [scope_pkg::CHN-1:0]                       loop_q;
  logic                                            cap_q;
  // per channel sample after conversion and loop mux
  scope_pkg::osc_t [scope_pkg::CHN-1:0]            samp;

  // sample registers, close to the pins
  always_ff @(posedge clk_i) begin
    adc_raw <= adc_dat_i;
    gen_raw <= gen_dat_i;
  end

  // loop select and capture enable travel with the data
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      loop_q <= '0;
      cap_q  <= 1'b0;
    end else begin
      loop_q <= loop_i;
      cap_q  <= capture_en_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // conversion and loopback
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < scope_pkg::CHN; i++) begin
      if (loop_q[i]) begin
        // sign extend then scale 14 bit gen up to osc range
        samp[i] = scope_pkg::osc_t'(gen_raw[i]) <<< scope_pkg::LOOP_SHIFT;
      end else begin
        // keep sign, flip magnitude bits
        samp[i] = {adc_raw[i][scope_pkg::ADC_W-1], ~adc_raw[i][scope_pkg::ADC_W-2:0]};
      end
    end
  end

  // output pair, payload only
  always_ff @(posedge clk_i) begin
    pair_o.ch0 <= samp[0];
    pair_o.ch1 <= samp[1];
  end

  // push lines up with the pair register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      push_o <= 1'b0;
    end else begin
      push_o <= cap_q;
    end
  end

endmodule

// File: verilog/capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo #(
  // number of pairs, power of two
  parameter int unsigned DEPTH = 16
) (
  input  logic             clk_i,
  input  logic             rst_i,
  // write side, no back-pressure
  input  logic             push_i,
  input  scope_pkg::pair_t pair_i,
  // read side
  input  logic             pop_i,
  output scope_pkg::pair_t pair_o,
  output logic             empty_o,
  // sticky, a pair was lost
  output logic             ovf_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  scope_pkg::pair_t mem [DEPTH];

  // extra msb tells a full wrap from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // full drops the push, empty drops the pop
  assign wr_en = push_i & ~full;
  assign rd_en = pop_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= pair_i;
    end
  end

  // registered head word
  always_ff @(posedge clk_i) begin
    pair_o <= mem[rd_ptr[AW-1:0]];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // status flags
  ////////////////////////////////////////////////////////////

  // empty lags one cycle so it matches the head register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      empty_o <= 1'b1;
      ovf_o   <= 1'b0;
    end else begin
      empty_o <= empty;
      // held until reset
      if (push_i && full) begin
        ovf_o <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/sample_readout.sv
`timescale 1ns/1ps

module sample_readout (
  input  logic             clk_i,
  input  logic             rst_i,
  // read request pulse
  input  logic             rd_i,
  // fifo head
  input  scope_pkg::pair_t pair_i,
  input  logic             empty_i,
  output logic             pop_o,
  // one channel per cycle
  output scope_pkg::osc_t  rd_dat_o,
  output logic             rd_ch_o,
  output logic             rd_vld_o
);

  ////////////////////////////////////////////////////////////
  // phase control
  ////////////////////////////////////////////////////////////

  // high during the ch0 cycle, ch1 goes out next
  logic            ch1_pend;
  // ch1 kept from the popped pair
  scope_pkg::osc_t ch1_q;
  logic            accept;

  // only taken when idle and data is there
  assign accept = rd_i & ~ch1_pend & ~empty_i;
  assign pop_o  = accept;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ch1_pend <= 1'b0;
      rd_vld_o <= 1'b0;
      rd_ch_o  <= 1'b0;
    end else if (accept) begin
      ch1_pend <= 1'b1;
      rd_vld_o <= 1'b1;
      rd_ch_o  <= 1'b0;
    end else if (ch1_pend) begin
      ch1_pend <= 1'b0;
      rd_vld_o <= 1'b1;
      rd_ch_o  <= 1'b1;
    end else begin
      rd_vld_o <= 1'b0;
    end
  end

  // data path, ch0 first then the held ch1
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_dat_o <= pair_i.ch0;
      ch1_q    <= pair_i.ch1;
    end else if (ch1_pend) begin
      rd_dat_o <= ch1_q;
    end
  end

endmodule

// File: verilog/dac_output.sv
`timescale 1ns/1ps

module dac_output (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // generator samples and their strobe
  input  scope_pkg::gen_t [scope_pkg::CHN-1:0] gen_dat_i,
  input  logic                                 gen_vld_i,
  // DAC codes, A is ch0 and B is ch1
  output scope_pkg::dac_t                      dac_a_o,
  output scope_pkg::dac_t                      dac_b_o
);

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  scope_pkg::dac_t [scope_pkg::CHN-1:0] dac_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      // park both DACs at mid-scale
      for (int i = 0; i < scope_pkg::CHN; i++) begin
        dac_q[i] <= scope_pkg::DAC_MID;
      end
    end else if (gen_vld_i) begin
      // signed to offset code, negative slope
      for (int i = 0; i < scope_pkg::CHN; i++) begin
        dac_q[i] <= {gen_dat_i[i][scope_pkg::GEN_W-1],
                     ~gen_dat_i[i][scope_pkg::GEN_W-2:0]};
      end
    end
  end

  assign dac_a_o = dac_q[0];
  assign dac_b_o = dac_q[1];

endmodule

// File: verilog/scope_top.sv
`timescale 1ns/1ps

module scope_top #(
  // capture buffer depth in pairs
  parameter int unsigned DEPTH = 16
) (
  input  logic                                            adc_clk,
  input  logic                                            top_rst,
  // ADC pins
  input  logic [scope_pkg::CHN-1:0][scope_pkg::ADC_W-1:0] adc_dat_i,
  // generator stream
  input  scope_pkg::gen_t [scope_pkg::CHN-1:0]            gen_dat_i,
  input  logic                                            gen_vld_i,
  // control
  input  logic [scope_pkg::CHN-1:0]                       loop_i,
  input  logic                                            capture_en_i,
  input  logic                                            rd_i,
  // DAC codes
  output scope_pkg::dac_t                                 dac_a_o,
  output scope_pkg::dac_t                                 dac_b_o,
  // readout
  output scope_pkg::osc_t                                 rd_dat_o,
  output logic                                            rd_ch_o,
  output logic                                            rd_vld_o,
  // buffer status
  output logic                                            empty_o,
  output logic                                            ovf_o
);

  ////////////////////////////////////////////////////////////
  // acquisition into the buffer
  ////////////////////////////////////////////////////////////

  logic             push;
  scope_pkg::pair_t push_pair;
  logic             pop;
  scope_pkg::pair_t head_pair;

  adc_frontend adc_frontend_inst (
    .clk_i        (adc_clk),
    .rst_i        (top_rst),
    .adc_dat_i    (adc_dat_i),
    .gen_dat_i    (gen_dat_i),
    .loop_i       (loop_i),
    .capture_en_i (capture_en_i),
    .push_o       (push),
    .pair_o       (push_pair)
  );

  capture_fifo #(
    .DEPTH (DEPTH)
  ) capture_fifo_inst (
    .clk_i   (adc_clk),
    .rst_i   (top_rst),
    .push_i  (push),
    .pair_i  (push_pair),
    .pop_i   (pop),
    .pair_o  (head_pair),
    .empty_o (empty_o),
    .ovf_o   (ovf_o)
  );

  ////////////////////////////////////////////////////////////
  // readout and DAC branch
  ////////////////////////////////////////////////////////////

  sample_readout sample_readout_inst (
    .clk_i    (adc_clk),
    .rst_i    (top_rst),
    .rd_i     (rd_i),
    .pair_i   (head_pair),
    .empty_i  (empty_o),
    .pop_o    (pop),
    .rd_dat_o (rd_dat_o),
    .rd_ch_o  (rd_ch_o),
    .rd_vld_o (rd_vld_o)
  );

  dac_output dac_output_inst (
    .clk_i     (adc_clk),
    .rst_i     (top_rst),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .dac_a_o   (dac_a_o),
    .dac_b_o   (dac_b_o)
  );

endmodule

// File: testbench/scope_model.svh
////////////////////////////////////////////////////////////
// reference model, stepped once per rising edge
////////////////////////////////////////////////////////////

// pairs the buffer should hold, oldest first
scope_pkg::pair_t m_q[$];
// inputs seen at the previous edge
logic [1:0][15:0] m_adc1;
logic [1:0][13:0] m_gen1;
logic [1:0]       m_loop1;
logic             m_cap1;
// converted pair and its write strobe
scope_pkg::pair_t m_pair2;
logic             m_push2;
logic             m_ovf;
logic [13:0]      m_dac_a;
logic [13:0]      m_dac_b;

// negative slope code to two's complement
function automatic logic [15:0] adc_to_osc(input logic [15:0] raw);
  return raw ^ 16'h7fff;
endfunction

// generator value times four, sign kept
function automatic logic [15:0] gen_to_osc(input logic [13:0] g);
  logic signed [15:0] ext;
  ext = $signed(g);
  return ext * 16'sd4;
endfunction

// two's complement to offset code, negative slope
function automatic logic [13:0] gen_to_dac(input logic [13:0] g);
  return g ^ 14'h1fff;
endfunction

task model_reset();
  m_q.delete();
  m_cap1  = 1'b0;
  m_push2 = 1'b0;
  m_ovf   = 1'b0;
  // DACs park at mid-scale
  m_dac_a = 14'h1fff;
  m_dac_b = 14'h1fff;
endtask

task model_edge(input logic [1:0][15:0] adc, input logic [1:0][13:0] gen,
                input logic vld, input logic [1:0] lp, input logic cap);
  // write sees the fill level before this edge
  if (m_push2) begin
    if (m_q.size() < DEPTH) begin
      m_q.push_back(m_pair2);
    end else begin
      m_ovf = 1'b1;
    end
  end
  m_pair2.ch0 = m_loop1[0] ? gen_to_osc(m_gen1[0]) : adc_to_osc(m_adc1[0]);
  m_pair2.ch1 = m_loop1[1] ? gen_to_osc(m_gen1[1]) : adc_to_osc(m_adc1[1]);
  m_push2     = m_cap1;
  m_adc1      = adc;
  m_gen1      = gen;
  m_loop1     = lp;
  m_cap1      = cap;
  if (vld) begin
    m_dac_a = gen_to_dac(gen[0]);
    m_dac_b = gen_to_dac(gen[1]);
  end
endtask

// File: testbench/scope_tb.sv
`timescale 1ns/1ps

module scope_tb;

  localparam int unsigned DEPTH   = 16;
  // longest any wait may take in cycles
  localparam int          TIMEOUT = 50;

  logic                  adc_clk;
  logic                  top_rst;
  logic [1:0][15:0]      adc_dat;
  scope_pkg::gen_t [1:0] gen_dat;
  logic                  gen_vld;
  logic [1:0]            loop_sel;
  logic                  capture_en;
  logic                  rd;
  scope_pkg::dac_t       dac_a;
  scope_pkg::dac_t       dac_b;
  scope_pkg::osc_t       rd_dat;
  logic                  rd_ch;
  logic                  rd_vld;
  logic                  empty;
  logic                  ovf;

  int seed;
  int n_checks;
  int n_value_err;
  int n_timeouts;
  bit model_on;

  scope_top #(
    .DEPTH (DEPTH)
  ) scope_top_inst (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat),
    .gen_dat_i    (gen_dat),
    .gen_vld_i    (gen_vld),
    .loop_i       (loop_sel),
    .capture_en_i (capture_en),
    .rd_i         (rd),
    .dac_a_o      (dac_a),
    .dac_b_o      (dac_b),
    .rd_dat_o     (rd_dat),
    .rd_ch_o      (rd_ch),
    .rd_vld_o     (rd_vld),
    .empty_o      (empty),
    .ovf_o        (ovf)
  );

  `include "scope_model.svh"

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task check_value(input string name, input logic [15:0] got, input logic [15:0] want);
    n_checks++;
    assert (got === want) else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
      n_value_err++;
    end
  endtask

  // steps one edge and the model and compares DAC and overflow
  task tick();
    @(posedge adc_clk);
    model_edge(adc_dat, gen_dat, gen_vld, loop_sel, capture_en);
    #1;
    if (model_on) begin
      check_value("dac_a_o", dac_a, m_dac_a);
      check_value("dac_b_o", dac_b, m_dac_b);
      check_value("ovf_o", ovf, m_ovf);
    end
  endtask

  task drive_random(input logic cap, input logic [1:0] lp);
    adc_dat[0] = 16'($random(seed));
    adc_dat[1] = 16'($random(seed));
    gen_dat[0] = 14'($random(seed));
    gen_dat[1] = 14'($random(seed));
    gen_vld    = 1'($random(seed));
    loop_sel   = lp;
    capture_en = cap;
  endtask

  task capture_burst(input int n, input logic [1:0] lp);
    for (int i = 0; i < n; i++) begin
      drive_random(1'b1, lp);
      tick();
    end
    drive_random(1'b0, lp);
    // last pairs still in the frontend pipe
    repeat (4) tick();
  endtask

  task read_pair();
    scope_pkg::pair_t want;
    logic             hold;
    int               waited;
    waited = 0;
    // a second rd during the ch0 cycle must be ignored
    hold   = 1'($random(seed));
    want   = m_q.pop_front();
    while (empty && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (empty) begin
      $display("timeout, capture buffer showed no data");
      n_timeouts++;
      return;
    end
    rd   = 1'b1;
    tick();
    rd     = hold;
    waited = 0;
    while (!rd_vld && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (!rd_vld) begin
      $display("timeout, no valid readout after a read request");
      n_timeouts++;
      rd = 1'b0;
      return;
    end
    check_value("rd_ch_o", rd_ch, 1'b0);
    check_value("rd_dat_o", rd_dat, want.ch0);
    tick();
    rd = 1'b0;
    check_value("rd_vld_o", rd_vld, 1'b1);
    check_value("rd_ch_o", rd_ch, 1'b1);
    check_value("rd_dat_o", rd_dat, want.ch1);
    tick();
    // falls as no new request was taken
    check_value("rd_vld_o", rd_vld, 1'b0);
  endtask

  task read_all();
    while (m_q.size() > 0) begin
      read_pair();
    end
    check_value("empty_o", empty, 1'b1);
  endtask

  task read_when_empty();
    check_value("empty_o", empty, 1'b1);
    rd = 1'b1;
    tick();
    rd = 1'b0;
    check_value("rd_vld_o", rd_vld, 1'b0);
    repeat (2) begin
      tick();
      check_value("rd_vld_o", rd_vld, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed        = 43310;
    n_checks    = 0;
    n_value_err = 0;
    n_timeouts  = 0;
    model_on    = 1'b0;
    adc_dat     = '0;
    gen_dat     = '0;
    gen_vld     = 1'b0;
    loop_sel    = 2'b00;
    capture_en  = 1'b0;
    rd          = 1'b0;
    top_rst     = 1'b1;
    repeat (4) tick();
    top_rst = 1'b0;
    model_reset();
    model_on = 1'b1;

    // state right after reset
    check_value("empty_o", empty, 1'b1);
    check_value("ovf_o", ovf, 1'b0);
    check_value("rd_vld_o", rd_vld, 1'b0);
    check_value("dac_a_o", dac_a, 14'h1fff);
    check_value("dac_b_o", dac_b, 14'h1fff);

    // ADC only
    repeat (6) begin
      capture_burst(1 + ({$random(seed)} % DEPTH), 2'b00);
      read_all();
    end
    // loop select drawn per burst
    repeat (6) begin
      capture_burst(1 + ({$random(seed)} % DEPTH), 2'($random(seed)));
      read_all();
    end

    // overrun the buffer without reads
    capture_burst(DEPTH + 6, 2'($random(seed)));
    check_value("ovf_o", ovf, 1'b1);
    read_all();
    read_when_empty();
    // flag sticks while data still flows
    capture_burst(5, 2'b01);
    read_all();

    $display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_value_err, n_timeouts);
    if (n_value_err == 0 && n_timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: scope.f
+incdir+testbench
verilog/scope_pkg.sv
verilog/adc_frontend.sv
verilog/capture_fifo.sv
verilog/sample_readout.sv
verilog/dac_output.sv
verilog/scope_top.sv
testbench/scope_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module scope_tb -f scope.f
	@out="$$(./obj_dir/Vscope_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
